//--- mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int INSTR_W = 32;

    ////////////////////////////////////////////////////////////
    // Primary opcodes
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // Function codes, R-type only
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    ////////////////////////////////////////////////////////////
    // Field positions
    ////////////////////////////////////////////////////////////
    localparam int OP_MSB    = 31, OP_LSB    = 26;
    localparam int RS_MSB    = 25, RS_LSB    = 21;
    localparam int RT_MSB    = 20, RT_LSB    = 16;
    localparam int RD_MSB    = 15, RD_LSB    = 11;
    localparam int SHAMT_MSB = 10, SHAMT_LSB = 6;
    localparam int FN_MSB    = 5,  FN_LSB    = 0;
    localparam int IMM_MSB   = 15, IMM_LSB   = 0;

endpackage

//--- pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath and storage sizes
    ////////////////////////////////////////////////////////////
    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 2 ** REG_ADDR_W;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;

    // ALU operations seen by the execute stage
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6
    } alu_op_t;

endpackage

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                                 Clk,
    input  logic                                 reset,
    input  logic [mips_isa_pkg::INSTR_W-1:0]     instr,
    input  logic                                 instr_valid,
    input  logic                                 ex_fwd_we,
    input  logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] ex_fwd_reg,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     ex_fwd_data,
    input  logic                                 wb_we,
    input  logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] wb_reg,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     wb_data,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     read_data1,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     read_data2,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     imm_ext,
    output logic [4:0]                           shamt,
    output logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] dest_reg,
    output pipe_ctrl_pkg::alu_op_t               alu_op,
    output logic                                 alu_src,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic                                 mem_to_reg,
    output logic                                 reg_write,
    output logic                                 valid
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [15:0]           imm;
    logic                  zero_ext;
    logic                  use_rd;
    logic [DATA_W-1:0]     reg_file [NUM_REGS];

    assign opcode = instr[OP_MSB:OP_LSB];
    assign funct  = instr[FN_MSB:FN_LSB];
    assign rs     = instr[RS_MSB:RS_LSB];
    assign rt     = instr[RT_MSB:RT_LSB];
    assign rd     = instr[RD_MSB:RD_LSB];
    assign shamt  = instr[SHAMT_MSB:SHAMT_LSB];
    assign imm    = instr[IMM_MSB:IMM_LSB];
    assign valid  = instr_valid;

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        alu_op     = ALU_ADD;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        zero_ext   = 1'b0;
        use_rd     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                use_rd    = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    // Unknown function code does nothing
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_SLTI: begin
                alu_op    = ALU_SLT;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_ANDI: begin
                alu_op    = ALU_AND;
                alu_src   = 1'b1;
                reg_write = 1'b1;
                zero_ext  = 1'b1;
            end
            OP_ORI: begin
                alu_op    = ALU_OR;
                alu_src   = 1'b1;
                reg_write = 1'b1;
                zero_ext  = 1'b1;
            end
            OP_LW: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    assign imm_ext  = zero_ext ? {{(DATA_W-16){1'b0}}, imm} : {{(DATA_W-16){imm[15]}}, imm};
    assign dest_reg = use_rd ? rd : rt;

    ////////////////////////////////////////////////////////////
    // Register file and operand forwarding
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                reg_file[i] <= '0;
            end
        end else if (wb_we) begin
            reg_file[wb_reg] <= wb_data;
        end
    end

    // Execute wins over write-back, write-back over the file
    function automatic logic [DATA_W-1:0] pick_operand(input logic [REG_ADDR_W-1:0] addr);
        logic [DATA_W-1:0] value;
        if (addr == '0)
            value = '0;
        else if (ex_fwd_we && ex_fwd_reg == addr)
            value = ex_fwd_data;
        else if (wb_we && wb_reg == addr)
            value = wb_data;
        else
            value = reg_file[addr];
        return value;
    endfunction

    always_comb begin
        read_data1 = pick_operand(rs);
        read_data2 = pick_operand(rt);
    end

    // Result stage must drop r0 writes before they reach the file
    a_no_r0_write: assert property (@(posedge Clk) disable iff (reset)
        wb_we |-> wb_reg != '0)
        else $error("decode: write-back flagged for register 0");

endmodule

//--- id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register (
    input  logic                                 Clk,
    input  logic                                 reset,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     read_data1,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     read_data2,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     imm_ext,
    input  logic [4:0]                           shamt,
    input  logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] dest_reg,
    input  pipe_ctrl_pkg::alu_op_t               alu_op,
    input  logic                                 alu_src,
    input  logic                                 mem_read,
    input  logic                                 mem_write,
    input  logic                                 mem_to_reg,
    input  logic                                 reg_write,
    input  logic                                 valid,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     read_data1_q,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     read_data2_q,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     imm_ext_q,
    output logic [4:0]                           shamt_q,
    output logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] dest_reg_q,
    output pipe_ctrl_pkg::alu_op_t               alu_op_q,
    output logic                                 alu_src_q,
    output logic                                 mem_read_q,
    output logic                                 mem_write_q,
    output logic                                 mem_to_reg_q,
    output logic                                 reg_write_q,
    output logic                                 valid_q
);
    import pipe_ctrl_pkg::*;

    logic alu_src_r;
    logic mem_read_r;
    logic mem_write_r;
    logic mem_to_reg_r;
    logic reg_write_r;

    always_ff @(posedge Clk) begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= valid;
    end

    // Payload and raw control, qualified by valid_q below
    always_ff @(posedge Clk) begin
        read_data1_q <= read_data1;
        read_data2_q <= read_data2;
        imm_ext_q    <= imm_ext;
        shamt_q      <= shamt;
        dest_reg_q   <= dest_reg;
        alu_op_q     <= alu_op;
        alu_src_r    <= alu_src;
        mem_read_r   <= mem_read;
        mem_write_r  <= mem_write;
        mem_to_reg_r <= mem_to_reg;
        reg_write_r  <= reg_write;
    end

    assign alu_src_q    = alu_src_r & valid_q;
    assign mem_read_q   = mem_read_r & valid_q;
    assign mem_write_q  = mem_write_r & valid_q;
    assign mem_to_reg_q = mem_to_reg_r & valid_q;
    assign reg_write_q  = reg_write_r & valid_q;

    a_valid_after_reset: assert property (@(posedge Clk) reset |=> !valid_q)
        else $error("id_ex: valid set in the cycle after reset");

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     read_data1,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     read_data2,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     imm_ext,
    input  logic [4:0]                           shamt,
    input  logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] dest_reg,
    input  pipe_ctrl_pkg::alu_op_t               alu_op,
    input  logic                                 alu_src,
    input  logic                                 mem_read,
    input  logic                                 mem_write,
    input  logic                                 mem_to_reg,
    input  logic                                 reg_write,
    input  logic                                 valid,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     alu_result,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     store_data,
    output logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] ex_dest_reg,
    output logic                                 ex_mem_read,
    output logic                                 ex_mem_write,
    output logic                                 ex_mem_to_reg,
    output logic                                 ex_reg_write,
    output logic                                 ex_valid,
    output logic                                 ex_fwd_we
);
    import pipe_ctrl_pkg::*;

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;

    assign op_a = read_data1;
    assign op_b = alu_src ? imm_ext : read_data2;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            // Shifts act on rt, which is op_b for R-type
            ALU_SLL: alu_result = op_b << shamt;
            ALU_SRL: alu_result = op_b >> shamt;
            default: alu_result = '0;
        endcase
    end

    assign store_data    = read_data2;
    assign ex_dest_reg   = dest_reg;
    assign ex_mem_read   = mem_read & valid;
    assign ex_mem_write  = mem_write & valid;
    assign ex_mem_to_reg = mem_to_reg & valid;
    assign ex_reg_write  = reg_write & valid;
    assign ex_valid      = valid;

    // Load data is not ready yet, so loads never forward from here
    assign ex_fwd_we = reg_write & valid & ~mem_read;

    always_comb begin
        if (valid) begin
            assert (alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                                   ALU_SLT, ALU_SLL, ALU_SRL})
                else $error("execute: undefined alu_op %0h", alu_op);
        end
    end

endmodule

//--- result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic                                 Clk,
    input  logic                                 reset,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     alu_result,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     store_data,
    input  logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] ex_dest_reg,
    input  logic                                 ex_mem_read,
    input  logic                                 ex_mem_write,
    input  logic                                 ex_mem_to_reg,
    input  logic                                 ex_reg_write,
    input  logic                                 ex_valid,
    output logic                                 wb_valid,
    output logic                                 wb_we,
    output logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] wb_reg,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     wb_data
);
    import pipe_ctrl_pkg::*;

    logic [DATA_W-1:0]      result_r;
    logic                   mem_to_reg_r;
    logic [DATA_W-1:0]      dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] ex_word_addr;
    logic [DMEM_ADDR_W-1:0] wb_word_addr;

    assign ex_word_addr = alu_result[DMEM_ADDR_W+1:2];
    assign wb_word_addr = result_r[DMEM_ADDR_W+1:2];

    always_ff @(posedge Clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            // Writes to r0 are dropped here
            wb_we    <= ex_reg_write & ex_valid & (ex_dest_reg != '0);
        end
    end

    always_ff @(posedge Clk) begin
        result_r     <= alu_result;
        wb_reg       <= ex_dest_reg;
        mem_to_reg_r <= ex_mem_to_reg;
    end

    ////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (ex_mem_write && ex_valid)
            dmem[ex_word_addr] <= store_data;
    end

    // Load reads from the registered address
    assign wb_data = mem_to_reg_r ? dmem[wb_word_addr] : result_r;

    a_rd_wr_exclusive: assert property (@(posedge Clk) disable iff (reset)
        !(ex_mem_read && ex_mem_write))
        else $error("result: load and store flagged together");

endmodule

//--- mips_pipe_top.sv
`timescale 1ns/1ps

module mips_pipe_top (
    input  logic                                 Clk,
    input  logic                                 reset,
    input  logic [mips_isa_pkg::INSTR_W-1:0]     instr,
    input  logic                                 instr_valid,
    output logic                                 wb_valid,
    output logic                                 wb_we,
    output logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] wb_reg,
    output logic [pipe_ctrl_pkg::DATA_W-1:0]     wb_data
);
    import pipe_ctrl_pkg::*;

    // Decode outputs
    logic [DATA_W-1:0]     read_data1, read_data2, imm_ext;
    logic [4:0]            shamt;
    logic [REG_ADDR_W-1:0] dest_reg;
    alu_op_t               alu_op;
    logic                  alu_src, mem_read, mem_write, mem_to_reg, reg_write, valid;

    // Registered decode outputs
    logic [DATA_W-1:0]     read_data1_q, read_data2_q, imm_ext_q;
    logic [4:0]            shamt_q;
    logic [REG_ADDR_W-1:0] dest_reg_q;
    alu_op_t               alu_op_q;
    logic                  alu_src_q, mem_read_q, mem_write_q, mem_to_reg_q;
    logic                  reg_write_q, valid_q;

    // Execute outputs
    logic [DATA_W-1:0]     alu_result, store_data;
    logic [REG_ADDR_W-1:0] ex_dest_reg;
    logic                  ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_reg_write;
    logic                  ex_valid, ex_fwd_we;

    decode_stage u_decode (
        .Clk, .reset, .instr, .instr_valid,
        .ex_fwd_we, .ex_fwd_reg(ex_dest_reg), .ex_fwd_data(alu_result),
        .wb_we, .wb_reg, .wb_data,
        .read_data1, .read_data2, .imm_ext, .shamt, .dest_reg,
        .alu_op, .alu_src, .mem_read, .mem_write, .mem_to_reg, .reg_write, .valid
    );

    id_ex_register u_id_ex (
        .Clk, .reset,
        .read_data1, .read_data2, .imm_ext, .shamt, .dest_reg,
        .alu_op, .alu_src, .mem_read, .mem_write, .mem_to_reg, .reg_write, .valid,
        .read_data1_q, .read_data2_q, .imm_ext_q, .shamt_q, .dest_reg_q,
        .alu_op_q, .alu_src_q, .mem_read_q, .mem_write_q, .mem_to_reg_q,
        .reg_write_q, .valid_q
    );

    execute_stage u_execute (
        .read_data1(read_data1_q), .read_data2(read_data2_q), .imm_ext(imm_ext_q),
        .shamt(shamt_q), .dest_reg(dest_reg_q), .alu_op(alu_op_q), .alu_src(alu_src_q),
        .mem_read(mem_read_q), .mem_write(mem_write_q), .mem_to_reg(mem_to_reg_q),
        .reg_write(reg_write_q), .valid(valid_q),
        .alu_result, .store_data, .ex_dest_reg, .ex_mem_read, .ex_mem_write,
        .ex_mem_to_reg, .ex_reg_write, .ex_valid, .ex_fwd_we
    );

    result_stage u_result (
        .Clk, .reset, .alu_result, .store_data, .ex_dest_reg,
        .ex_mem_read, .ex_mem_write, .ex_mem_to_reg, .ex_reg_write, .ex_valid,
        .wb_valid, .wb_we, .wb_reg, .wb_data
    );

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic                                 Clk,
    input  logic                                 reset,
    input  logic                                 wb_valid,
    input  logic                                 wb_we,
    input  logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] wb_reg,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     wb_data,
    input  logic                                 exp_push,
    input  logic                                 exp_we,
    input  logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] exp_reg,
    input  logic [pipe_ctrl_pkg::DATA_W-1:0]     exp_data,
    output int                                   pending,
    output int                                   checks,
    output int                                   errors
);
    import pipe_ctrl_pkg::*;

    // Write-back is due two edges after issue
    localparam int WB_LATENCY  = 2;
    localparam int MAX_LATENCY = 4;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] reg_num;
        logic [DATA_W-1:0]     data;
    } expect_t;

    expect_t expected_q[$];
    int      issued_at[$];
    int      cycle = 0;

    always @(posedge Clk) begin
        expect_t head;
        expect_t incoming;
        int      issue_cycle;
        int      new_checks;
        int      new_errors;
        new_checks = 0;
        new_errors = 0;
        if (reset) begin
            expected_q.delete();
            issued_at.delete();
            checks <= 0;
            errors <= 0;
        end else begin
            cycle = cycle + 1;
            if (wb_we === 1'b1 && wb_valid !== 1'b1) begin
                $display("Fail at %0t: wb_we expected 0 actual 1 (wb_valid low)", $time);
                new_errors++;
            end

            ////////////////////////////////////////////////////////////
            // Compare the oldest outstanding row
            ////////////////////////////////////////////////////////////
            if (wb_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("Write-back at %0t with no instruction outstanding", $time);
                    new_errors++;
                end else begin
                    head        = expected_q.pop_front();
                    issue_cycle = issued_at.pop_front();
                    new_checks++;
                    if (cycle - issue_cycle != WB_LATENCY) begin
                        $display("Fail at %0t: wb_valid latency expected %0d actual %0d",
                                 $time, WB_LATENCY, cycle - issue_cycle);
                        new_errors++;
                    end
                    if (wb_we !== head.we) begin
                        $display("Fail at %0t: wb_we expected %0b actual %0b",
                                 $time, head.we, wb_we);
                        new_errors++;
                    end else if (head.we) begin
                        if (wb_reg !== head.reg_num) begin
                            $display("Fail at %0t: wb_reg expected %0d actual %0d",
                                     $time, head.reg_num, wb_reg);
                            new_errors++;
                        end
                        if (wb_data !== head.data) begin
                            $display("Fail at %0t: wb_data expected %08h actual %08h",
                                     $time, head.data, wb_data);
                            new_errors++;
                        end
                    end
                end
            end

            // Oldest instruction overdue
            if (issued_at.size() != 0 && cycle - issued_at[0] >= MAX_LATENCY) begin
                $display("No write-back at %0t within %0d cycles of the issued instruction",
                         $time, MAX_LATENCY);
                new_errors++;
                expected_q.delete(0);
                issued_at.delete(0);
            end

            if (exp_push) begin
                incoming.we      = exp_we;
                incoming.reg_num = exp_reg;
                incoming.data    = exp_data;
                expected_q.push_back(incoming);
                issued_at.push_back(cycle);
            end
            checks <= checks + new_checks;
            errors <= errors + new_errors;
        end
        pending <= expected_q.size();
    end

endmodule

//--- tb_mips_pipe.sv
`timescale 1ns/1ps

module tb_mips_pipe;
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    localparam int DRAIN_CYCLES = 20;

    typedef struct packed {
        logic [INSTR_W-1:0]    instr;
        logic                  valid;
        logic                  we;
        logic [REG_ADDR_W-1:0] reg_num;
        logic [DATA_W-1:0]     data;
    } row_t;

    logic                  Clk = 1'b0;
    logic                  reset;
    logic [INSTR_W-1:0]    instr;
    logic                  instr_valid;
    logic                  wb_valid;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_reg;
    logic [DATA_W-1:0]     wb_data;
    logic                  exp_push;
    logic                  exp_we;
    logic [REG_ADDR_W-1:0] exp_reg;
    logic [DATA_W-1:0]     exp_data;
    int                    pending;
    int                    checks;
    int                    errors;
    int                    timeouts;
    int                    issued;
    int                    wait_cycles;
    row_t                  rows[$];

    mips_pipe_top dut (
        .Clk, .reset, .instr, .instr_valid, .wb_valid, .wb_we, .wb_reg, .wb_data
    );

    tb_checker chk (
        .Clk, .reset, .wb_valid, .wb_we, .wb_reg, .wb_data,
        .exp_push, .exp_we, .exp_reg, .exp_data, .pending, .checks, .errors
    );

    always #10 Clk = ~Clk;

    function automatic logic [31:0] r_word(input logic [5:0] fn, input int rd, input int rs,
                                           input int rt, input int sh);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input int rt, input int rs,
                                           input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic append_row(input logic [31:0] word, input logic we, input int rd,
                              input logic [31:0] data);
        row_t row;
        row.instr   = word;
        row.valid   = 1'b1;
        row.we      = we;
        row.reg_num = rd[4:0];
        row.data    = data;
        rows.push_back(row);
    endtask

    task automatic idle_row();
        row_t row;
        row = '0;
        rows.push_back(row);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table with expected write-back
    ////////////////////////////////////////////////////////////
    task automatic build_table();
        // Fresh registers read as zero
        append_row(r_word(FN_ADD, 3, 5, 6, 0), 1'b1, 3, 32'h0000_0000);
        append_row(i_word(OP_ADDI, 1, 0, -5), 1'b1, 1, 32'hFFFF_FFFB);
        append_row(i_word(OP_ORI, 2, 0, 'h8001), 1'b1, 2, 32'h0000_8001);
        append_row(i_word(OP_ANDI, 4, 1, 'hF0F0), 1'b1, 4, 32'h0000_F0F0);
        append_row(i_word(OP_SLTI, 5, 1, -3), 1'b1, 5, 32'h0000_0001);
        append_row(i_word(OP_SLTI, 6, 1, -7), 1'b1, 6, 32'h0000_0000);
        append_row(r_word(FN_ADD, 7, 1, 2, 0), 1'b1, 7, 32'h0000_7FFC);
        append_row(r_word(FN_SUB, 8, 7, 2, 0), 1'b1, 8, 32'hFFFF_FFFB);
        append_row(r_word(FN_AND, 9, 8, 2, 0), 1'b1, 9, 32'h0000_8001);
        append_row(r_word(FN_OR, 10, 7, 4, 0), 1'b1, 10, 32'h0000_FFFC);
        append_row(r_word(FN_SLT, 11, 8, 2, 0), 1'b1, 11, 32'h0000_0001);
        append_row(r_word(FN_SLT, 12, 2, 8, 0), 1'b1, 12, 32'h0000_0000);
        append_row(r_word(FN_SLL, 13, 0, 2, 4), 1'b1, 13, 32'h0008_0010);
        append_row(r_word(FN_SRL, 14, 0, 1, 28), 1'b1, 14, 32'h0000_000F);
        // Execute value must win over the older write-back value
        append_row(i_word(OP_ADDI, 15, 0, 100), 1'b1, 15, 32'h0000_0064);
        append_row(i_word(OP_ADDI, 15, 0, 200), 1'b1, 15, 32'h0000_00C8);
        append_row(r_word(FN_ADD, 16, 15, 15, 0), 1'b1, 16, 32'h0000_0190);
        append_row(i_word(OP_ADDI, 17, 0, 7), 1'b1, 17, 32'h0000_0007);
        idle_row();
        append_row(r_word(FN_ADD, 18, 17, 17, 0), 1'b1, 18, 32'h0000_000E);
        // Store, gap, load
        append_row(i_word(OP_SW, 7, 0, 8), 1'b0, 7, 32'h0000_0000);
        idle_row();
        append_row(i_word(OP_LW, 19, 0, 8), 1'b1, 19, 32'h0000_7FFC);
        idle_row();
        append_row(r_word(FN_ADD, 20, 19, 0, 0), 1'b1, 20, 32'h0000_7FFC);
        append_row(i_word(OP_ADDI, 21, 0, 'h1234), 1'b1, 21, 32'h0000_1234);
        append_row(i_word(OP_SW, 21, 0, 12), 1'b0, 21, 32'h0000_0000);
        idle_row();
        append_row(i_word(OP_LW, 22, 0, 12), 1'b1, 22, 32'h0000_1234);
        // r0 stays zero
        append_row(i_word(OP_ADDI, 0, 0, 9), 1'b0, 0, 32'h0000_0000);
        append_row(r_word(FN_ADD, 23, 0, 0, 0), 1'b1, 23, 32'h0000_0000);
        append_row(r_word(FN_OR, 24, 1, 0, 0), 1'b1, 24, 32'hFFFF_FFFB);
    endtask

    initial begin
        reset       <= 1'b1;
        instr       <= '0;
        instr_valid <= 1'b0;
        exp_push    <= 1'b0;
        exp_we      <= 1'b0;
        exp_reg     <= '0;
        exp_data    <= '0;
        timeouts    = 0;
        issued      = 0;
        build_table();
        repeat (2) @(posedge Clk);
        reset <= 1'b0;

        foreach (rows[i]) begin
            instr       <= rows[i].instr;
            instr_valid <= rows[i].valid;
            exp_push    <= rows[i].valid;
            exp_we      <= rows[i].we;
            exp_reg     <= rows[i].reg_num;
            exp_data    <= rows[i].data;
            if (rows[i].valid)
                issued++;
            @(posedge Clk);
        end
        instr_valid <= 1'b0;
        exp_push    <= 1'b0;
        @(posedge Clk);

        // Let the pipeline drain
        wait_cycles = 0;
        while (pending != 0 && wait_cycles < DRAIN_CYCLES) begin
            @(posedge Clk);
            wait_cycles++;
        end
        if (pending != 0) begin
            $display("Pipeline did not drain: %0d write-backs still missing after %0d cycles",
                     pending, DRAIN_CYCLES);
            timeouts++;
        end
        @(posedge Clk);

        $display("Issued: %0d, checks: %0d, errors: %0d, timeouts: %0d",
                 issued, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks == issued)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- sources.f
mips_isa_pkg.sv
pipe_ctrl_pkg.sv
decode_stage.sv
id_ex_register.sv
execute_stage.sv
result_stage.sv
mips_pipe_top.sv
tb_checker.sv
tb_mips_pipe.sv

//--- Makefile
# Verilator simulation of the pipelined core
TOP = tb_mips_pipe

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f *.sv
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
